/* flist.f */
+incdir+common
common/rp_pkg.sv
rtl/adc_frontend.sv
rtl/dac_backend.sv
regs/sys_regs.sv
pdm/pdm_modulator.sv
rtl/rp_top.sv
testbench/tb_rp_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds the Verilator model of tb_rp_top and runs it
# exit status is nonzero when the build or a check fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
  -f flist.f --top-module tb_rp_top \
  -Mdir obj_dir -o tb_rp_top \
  && ./obj_dir/tb_rp_top \
  && echo "simulation finished" \
  || { echo "simulation or build failed"; exit 1; }

/* testbench/tb_rp_top.sv */
////////////////////////////////////////
// directed tests for rp_top, 100 ns adc_clk
// inputs change on the falling edge
// first mismatch or timeout ends the run
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module tb_rp_top;

  import rp_pkg::*;

  // cycles to wait for a bus ack
  localparam int ACK_TIMEOUT = 20;

  logic                           adc_clk = 1'b0;
  logic                           top_rst;
  adc_raw_t  [`RP_CHN-1:0]        adc_dat;
  gen_str_t  [`RP_CHN-1:0]        gen;
  osc_str_t  [`RP_CHN-1:0]        osc;
  dac_code_t [`RP_CHN-1:0]        dac_dat;
  logic      [`RP_PDM_CHN-1:0]    pdm;
  sys_req_t                       sys_req;
  sys_rsp_t                       sys_rsp;

  logic [31:0] rng_state = 32'h2c1a5df2;

  always #50 adc_clk = ~adc_clk;

  rp_top uut (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .gen_i     (gen),
    .osc_o     (osc),
    .dac_dat_o (dac_dat),
    .pdm_o     (pdm),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // xorshift32 step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // region in the upper nibble
  function automatic logic [`RP_SYS_AW-1:0] reg_addr(input sys_region_e region,
                                                     input logic [3:0] idx);
    return {region, idx};
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // one request, then wait for the ack pulse
  task automatic bus_access(input sys_op_e op, input logic [`RP_SYS_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge adc_clk);
    sys_req = '{op: op, addr: addr, wdata: wdata};
    @(negedge adc_clk);
    sys_req = '{op: SYS_IDLE, addr: '0, wdata: '0};
    while (!sys_rsp.ack) begin
      if (waited == ACK_TIMEOUT) begin
        $display("timeout: no ack for the bus request at address %h", addr);
        $display("CHECKS FAILED");
        $fatal(1, "bus did not respond");
      end else begin
        waited++;
        @(negedge adc_clk);
      end
    end
    rdata = sys_rsp.rdata;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic test_reset();
    logic [31:0] rd;
    @(negedge adc_clk);
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      // adc pipe not filled yet
      check("reset osc vld", 32'h0, {31'h0, osc[ch].vld});
      check("reset dac mid-scale", 32'h1fff, {18'h0, dac_dat[ch]});
    end
    check("reset pdm", 32'h0, {28'h0, pdm});
    check("reset ack", 32'h0, {31'h0, sys_rsp.ack});
    bus_access(SYS_READ, reg_addr(REGION_ID, 4'h0), 32'h0, rd);
    check("reset id read", `RP_ID_VALUE, rd);
    // unmapped, still acked
    bus_access(SYS_READ, 8'h35, 32'h0, rd);
    check("reset unused read", 32'h0, rd);
  endtask

  task automatic test_adc_path();
    adc_raw_t [`RP_CHN-1:0] sent [$];
    adc_raw_t [`RP_CHN-1:0] words;
    logic [31:0]            r;
    for (int n = 0; n < 40; n++) begin
      @(negedge adc_clk);
      // sample from two edges back
      if (sent.size() == 2) begin
        words = sent.pop_front();
        for (int ch = 0; ch < `RP_CHN; ch++) begin
          check("adc_path vld", 32'h1, {31'h0, osc[ch].vld});
          check("adc_path dat", {16'h0, words[ch] ^ 16'h7fff}, {16'h0, osc[ch].dat});
        end
      end
      for (int ch = 0; ch < `RP_CHN; ch++) begin
        r = next_rand();
        adc_dat[ch] = r[15:0];
      end
      sent.push_back(adc_dat);
    end
  endtask

  task automatic test_dac_path();
    dac_code_t [`RP_CHN-1:0] exp_code;
    logic [31:0]             r;
    // still mid-scale, no valid sample so far
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      exp_code[ch] = 14'h1fff;
    end
    for (int n = 0; n < 48; n++) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `RP_CHN; ch++) begin
        check("dac_path", {18'h0, exp_code[ch]}, {18'h0, dac_dat[ch]});
        r = next_rand();
        gen[ch].vld = r[20];
        gen[ch].dat = r[13:0];
        // sign kept, other bits inverted
        if (r[20]) begin
          exp_code[ch] = r[13:0] ^ 14'h1fff;
        end
      end
    end
    @(negedge adc_clk);
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      check("dac_path last", {18'h0, exp_code[ch]}, {18'h0, dac_dat[ch]});
      gen[ch].vld = 1'b0;
    end
  endtask

  task automatic test_loopback();
    gen_str_t [`RP_CHN-1:0] gen_sent [$];
    adc_raw_t [`RP_CHN-1:0] adc_sent [$];
    gen_str_t [`RP_CHN-1:0] g;
    adc_raw_t [`RP_CHN-1:0] w;
    logic [31:0]            r;
    logic [31:0]            rd;
    // loop on channel 0 only
    bus_access(SYS_WRITE, reg_addr(REGION_MGMT, 4'h0), 32'h1, rd);
    bus_access(SYS_READ, reg_addr(REGION_MGMT, 4'h0), 32'h0, rd);
    check("loopback readback", 32'h1, rd);
    for (int n = 0; n < 40; n++) begin
      @(negedge adc_clk);
      if (gen_sent.size() == 1) begin
        g = gen_sent.pop_front();
        check("loopback ch0 vld", {31'h0, g[0].vld}, {31'h0, osc[0].vld});
        check("loopback ch0 dat", {16'h0, g[0].dat, 2'b00}, {16'h0, osc[0].dat});
      end
      if (adc_sent.size() == 2) begin
        w = adc_sent.pop_front();
        check("loopback ch1 vld", 32'h1, {31'h0, osc[1].vld});
        check("loopback ch1 dat", {16'h0, w[1] ^ 16'h7fff}, {16'h0, osc[1].dat});
      end
      for (int ch = 0; ch < `RP_CHN; ch++) begin
        r = next_rand();
        gen[ch].vld = r[24];
        gen[ch].dat = r[13:0];
        adc_dat[ch] = r[31:16];
      end
      gen_sent.push_back(gen);
      adc_sent.push_back(adc_dat);
    end
    // back to the adc path
    bus_access(SYS_WRITE, reg_addr(REGION_MGMT, 4'h0), 32'h0, rd);
    bus_access(SYS_READ, reg_addr(REGION_MGMT, 4'h0), 32'h0, rd);
    check("loopback restore", 32'h0, rd);
    for (int ch = 0; ch < `RP_CHN; ch++) begin
      gen[ch].vld = 1'b0;
    end
  endtask

  task automatic test_pdm();
    logic [7:0]  vals [`RP_PDM_CHN];
    int          counts [`RP_PDM_CHN];
    logic [31:0] rd;
    vals[0] = 8'd0;
    vals[1] = 8'd1;
    vals[2] = 8'd128;
    vals[3] = 8'd255;
    for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
      bus_access(SYS_WRITE, reg_addr(REGION_PDM, 4'(ch)), {24'h0, vals[ch]}, rd);
    end
    for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
      bus_access(SYS_READ, reg_addr(REGION_PDM, 4'(ch)), 32'h0, rd);
      check("pdm readback", {24'h0, vals[ch]}, rd);
      counts[ch] = 0;
    end
    // let the values settle
    repeat (4) @(negedge adc_clk);
    repeat (255) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
        if (pdm[ch]) begin
          counts[ch]++;
        end
      end
    end
    // ones per 255 cycles equal the value
    for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
      check("pdm density", {24'h0, vals[ch]}, 32'(counts[ch]));
    end
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    top_rst = 1'b1;
    adc_dat = '0;
    gen     = '0;
    sys_req = '{op: SYS_IDLE, addr: '0, wdata: '0};
    repeat (16) @(negedge adc_clk);
    top_rst = 1'b0;
    test_reset();
    test_adc_path();
    test_dac_path();
    test_loopback();
    test_pdm();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : tb_rp_top

`default_nettype wire

/* rtl/rp_top.sv */
////////////////////////////////////////
// analog data path top level
// single clock adc_clk, top_rst async high
// DAC channels leave as parallel words
// streams carry no ready, data is not held
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module rp_top (
  // clock and reset
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  // ADC pins
  input  rp_pkg::adc_raw_t  [`RP_CHN-1:0]      adc_dat_i,
  // generator stream in
  input  rp_pkg::gen_str_t  [`RP_CHN-1:0]      gen_i,
  // oscilloscope stream out
  output rp_pkg::osc_str_t  [`RP_CHN-1:0]      osc_o,
  // DAC pins, one word per channel
  output rp_pkg::dac_code_t [`RP_CHN-1:0]      dac_dat_o,
  // PDM pins
  output logic              [`RP_PDM_CHN-1:0]  pdm_o,
  // register bus
  input  rp_pkg::sys_req_t                     sys_req_i,
  output rp_pkg::sys_rsp_t                     sys_rsp_o
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  // loop select, one bit per channel
  logic [`RP_CHN-1:0] loop_sel;

  // PDM values from the register file
  rp_pkg::pdm_val_t [`RP_PDM_CHN-1:0] pdm_val;

  ////////////////////////////////////////
  // ADC side
  ////////////////////////////////////////

  // io regs, code conversion, loop mux
  adc_frontend adc_frontend (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .gen_i      (gen_i),
    .loop_sel_i (loop_sel),
    .osc_o      (osc_o)
  );

  ////////////////////////////////////////
  // DAC side
  ////////////////////////////////////////

  // generator samples also feed the loop above
  dac_backend dac_backend (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .gen_i      (gen_i),
    .dac_dat_o  (dac_dat_o)
  );

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // id, management, pdm values
  sys_regs sys_regs (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .sys_req_i  (sys_req_i),
    .sys_rsp_o  (sys_rsp_o),
    .loop_sel_o (loop_sel),
    .pdm_val_o  (pdm_val)
  );

  ////////////////////////////////////////
  // PDM analog outputs
  ////////////////////////////////////////

  // fixed range, always enabled
  pdm_modulator pdm_modulator (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .pdm_val_i  (pdm_val),
    .pdm_o      (pdm_o)
  );

endmodule : rp_top

`default_nettype wire

/* pdm/pdm_modulator.sv */
////////////////////////////////////////
// first order PDM, range fixed to 255
// density is value/255 per channel
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module pdm_modulator (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  input  rp_pkg::pdm_val_t [`RP_PDM_CHN-1:0]   pdm_val_i,
  output logic             [`RP_PDM_CHN-1:0]   pdm_o
);

  import rp_pkg::*;

  // one extra bit for the sum
  localparam int unsigned SUM_W = `RP_PDM_DW + 1;
  localparam logic [SUM_W-1:0] RNG = SUM_W'(`RP_PDM_RNG);

  ////////////////////////////////////////
  // accumulators
  ////////////////////////////////////////

  for (genvar i = 0; i < `RP_PDM_CHN; i++) begin : g_chn
    pdm_val_t         acc_q;
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] sum_wrap;
    logic             over;
    logic             pdm_q;

    // accumulator stays below the range
    assign sum      = SUM_W'(acc_q) + SUM_W'(pdm_val_i[i]);
    assign over     = (sum >= RNG);
    assign sum_wrap = sum - RNG;

    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        acc_q <= '0;
        pdm_q <= 1'b0;
      end else begin
        // overflow emits a one
        pdm_q <= over;
        acc_q <= over ? pdm_val_t'(sum_wrap) : pdm_val_t'(sum);
      end
    end

    assign pdm_o[i] = pdm_q;
  end : g_chn

endmodule : pdm_modulator

`default_nettype wire

/* regs/sys_regs.sv */
////////////////////////////////////////
// register bus slave, one request at a time
// ack one cycle after the request
// unmapped reads return 0 and still ack
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module sys_regs (
  input  logic                                 adc_clk,
  input  logic                                 top_rst,
  input  rp_pkg::sys_req_t                     sys_req_i,
  output rp_pkg::sys_rsp_t                     sys_rsp_o,
  output logic              [`RP_CHN-1:0]      loop_sel_o,
  output rp_pkg::pdm_val_t  [`RP_PDM_CHN-1:0]  pdm_val_o
);

  import rp_pkg::*;

  // index width below the region nibble
  localparam int unsigned IDX_W = `RP_SYS_AW - $bits(sys_region_e);
  // bits needed to pick a PDM register
  localparam int unsigned PDM_IW = $clog2(`RP_PDM_CHN);

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  sys_region_e             region;
  logic [IDX_W-1:0]        idx;
  logic                    pdm_hit;
  logic [`RP_SYS_DW-1:0]   rd_mux;

  // upper nibble region, lower nibble index
  assign region = sys_region_e'(sys_req_i.addr[`RP_SYS_AW-1:IDX_W]);
  assign idx    = sys_req_i.addr[IDX_W-1:0];

  // index within the pdm register range
  assign pdm_hit = (idx < IDX_W'(`RP_PDM_CHN));

  // registers
  logic [`RP_CHN-1:0]              loop_q;
  pdm_val_t [`RP_PDM_CHN-1:0]      pdm_q;
  logic                            ack_q;
  logic [`RP_SYS_DW-1:0]           rdata_q;

  // read data selection
  always_comb begin
    rd_mux = '0;
    case (region)
      REGION_ID: begin
        if (idx == '0) begin
          rd_mux = `RP_ID_VALUE;
        end
      end
      REGION_MGMT: begin
        if (idx == '0) begin
          rd_mux = `RP_SYS_DW'(loop_q);
        end
      end
      REGION_PDM: begin
        if (pdm_hit) begin
          rd_mux = `RP_SYS_DW'(pdm_q[idx[PDM_IW-1:0]]);
        end
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // write and ack
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      loop_q <= '0;
      pdm_q  <= '0;
      ack_q  <= 1'b0;
    end else begin
      // any request is acked next cycle
      ack_q <= (sys_req_i.op != SYS_IDLE);
      if (sys_req_i.op == SYS_WRITE) begin
        // loop bits at mgmt index 0
        if (region == REGION_MGMT && idx == '0) begin
          loop_q <= sys_req_i.wdata[`RP_CHN-1:0];
        end
        // one pdm value per index
        if (region == REGION_PDM && pdm_hit) begin
          pdm_q[idx[PDM_IW-1:0]] <= sys_req_i.wdata[`RP_PDM_DW-1:0];
        end
      end
    end
  end

  // read data, valid only with ack
  always_ff @(posedge adc_clk) begin
    if (sys_req_i.op == SYS_READ) begin
      rdata_q <= rd_mux;
    end
  end

  assign sys_rsp_o  = '{ack: ack_q, rdata: rdata_q};
  assign loop_sel_o = loop_q;
  assign pdm_val_o  = pdm_q;

endmodule : sys_regs

`default_nettype wire

/* rtl/dac_backend.sv */
////////////////////////////////////////
// DAC output registers
// code loads only on a valid sample
// reset value is mid-scale 14'h1FFF
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module dac_backend (
  input  logic                              adc_clk,
  input  logic                              top_rst,
  input  rp_pkg::gen_str_t  [`RP_CHN-1:0]   gen_i,
  output rp_pkg::dac_code_t [`RP_CHN-1:0]   dac_dat_o
);

  import rp_pkg::*;

  // mid-scale in negative slope offset code
  localparam dac_code_t DAC_MID = dac_code_t'((1 << (`RP_DAC_DW - 1)) - 1);

  ////////////////////////////////////////
  // per channel code registers
  ////////////////////////////////////////

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn
    gen_smp_t  smp;
    dac_code_t dac_conv;
    dac_code_t dac_q;

    assign smp = gen_i[i].dat;

    // signed to unsigned, slope reversed
    // keep sign bit, flip the rest
    assign dac_conv = {smp[`RP_DAC_DW-1], ~smp[`RP_DAC_DW-2:0]};

    // output register, holds without a strobe
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        dac_q <= DAC_MID;
      end else if (gen_i[i].vld) begin
        dac_q <= dac_conv;
      end
    end

    // straight to the pins
    assign dac_dat_o[i] = dac_q;
  end : g_chn

endmodule : dac_backend

`default_nettype wire

/* rtl/adc_frontend.sv */
////////////////////////////////////////
// ADC input registers and loop selection
// ADC path 2 cycles, loop path 1 cycle
// ADC words have vld high once pipe fills
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "rp_cfg.svh"

module adc_frontend (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  input  rp_pkg::adc_raw_t [`RP_CHN-1:0]   adc_dat_i,
  input  rp_pkg::gen_str_t [`RP_CHN-1:0]   gen_i,
  input  logic             [`RP_CHN-1:0]   loop_sel_i,
  output rp_pkg::osc_str_t [`RP_CHN-1:0]   osc_o
);

  import rp_pkg::*;

  // valid for the io register stage, low right after reset
  logic adc_vld_q;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_vld_q <= 1'b0;
    end else begin
      adc_vld_q <= 1'b1;
    end
  end

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn
    adc_raw_t adc_raw_q;
    osc_smp_t adc_conv;
    osc_smp_t gen_shift;
    logic     osc_vld_q;
    osc_smp_t osc_dat_q;

    // io register, meant to sit in the pad
    always_ff @(posedge adc_clk) begin
      adc_raw_q <= adc_dat_i[i];
    end

    // negative slope offset code to two's complement
    assign adc_conv = {adc_raw_q[`RP_ADC_DW-1], ~adc_raw_q[`RP_ADC_DW-2:0]};

    // 14 bit generator word up to 16 bit scope word
    assign gen_shift = osc_smp_t'(gen_i[i].dat) <<< `RP_LOOP_SHIFT;

    // stream valid
    always_ff @(posedge adc_clk or posedge top_rst) begin
      if (top_rst) begin
        osc_vld_q <= 1'b0;
      end else begin
        osc_vld_q <= loop_sel_i[i] ? gen_i[i].vld : adc_vld_q;
      end
    end

    // stream data
    always_ff @(posedge adc_clk) begin
      osc_dat_q <= loop_sel_i[i] ? gen_shift : adc_conv;
    end

    assign osc_o[i] = '{vld: osc_vld_q, dat: osc_dat_q};
  end : g_chn

endmodule : adc_frontend

`default_nettype wire

/* common/rp_pkg.sv */
////////////////////////////////////////
// sample, stream and bus types
// widths follow rp_cfg.svh
////////////////////////////////////////

`default_nettype none

`include "rp_cfg.svh"

package rp_pkg;

  // raw ADC word, negative-slope offset code
  typedef logic [`RP_ADC_DW-1:0] adc_raw_t;
  // oscilloscope sample, two's complement
  typedef logic signed [`RP_ADC_DW-1:0] osc_smp_t;
  // generator sample, two's complement
  typedef logic signed [`RP_DAC_DW-1:0] gen_smp_t;
  // DAC code, negative-slope offset code
  typedef logic [`RP_DAC_DW-1:0] dac_code_t;

  // generator stream beat
  typedef struct packed {
    logic     vld;
    gen_smp_t dat;
  } gen_str_t;

  // oscilloscope stream beat
  typedef struct packed {
    logic     vld;
    osc_smp_t dat;
  } osc_str_t;

  // PDM density value
  typedef logic [`RP_PDM_DW-1:0] pdm_val_t;

  // bus opcodes
  typedef enum logic [1:0] {
    SYS_IDLE,
    SYS_READ,
    SYS_WRITE
  } sys_op_e;

  // address regions, upper nibble of addr
  typedef enum logic [3:0] {
    REGION_ID   = 4'd0,
    REGION_MGMT = 4'd1,
    REGION_PDM  = 4'd2
  } sys_region_e;

  // request, held for one cycle by the master
  typedef struct packed {
    sys_op_e                op;
    logic [`RP_SYS_AW-1:0]  addr;
    logic [`RP_SYS_DW-1:0]  wdata;
  } sys_req_t;

  // response, ack pulse with read data
  typedef struct packed {
    logic                   ack;
    logic [`RP_SYS_DW-1:0]  rdata;
  } sys_rsp_t;

endpackage : rp_pkg

`default_nettype wire

/* common/rp_cfg.svh */
////////////////////////////////////////
// global widths and the register bus map
// all blocks share a single adc_clk domain
// ID value is fixed at build time
////////////////////////////////////////

`ifndef RP_CFG_SVH
`define RP_CFG_SVH

// analog channels, ADC and DAC alike
`define RP_CHN 2

// converter word widths
`define RP_ADC_DW 16
`define RP_DAC_DW 14

// generator to oscilloscope width alignment
`define RP_LOOP_SHIFT 2

// PDM outputs
`define RP_PDM_CHN 4
`define RP_PDM_DW 8
`define RP_PDM_RNG 255

// bus, addr[7:4] region, addr[3:0] index
`define RP_SYS_AW 8
`define RP_SYS_DW 32

// identification word
`define RP_ID_VALUE 32'h52504130

`endif
